// File: scc_defs.svh
// Constants are fixed by the SCC memory map; changing them breaks register and wave decoding
`ifndef SCC_DEFS_SVH
`define SCC_DEFS_SVH

// Tone channels and samples per wave
`define SCC_NUM_CH          5
`define SCC_WAVE_LEN        32

// Mixer slots per output frame, slot 0 closes the frame
`define SCC_NUM_SLOTS       6

// Address pages of the channel registers (adr[7:5])
`define SCC_PAGE_REG_SCC    3'b100
`define SCC_PAGE_REG_PLUS   3'b101

// Address pages of the mode register, picked by the chip type
`define SCC_PAGE_MODE_SCC   3'b111
`define SCC_PAGE_MODE_PLUS  3'b110

`endif

// File: scc_pkg.sv
// Shared SCC types; the bus carries plain levels with no handshake beyond the one-cycle ack
`default_nettype none

`include "scc_defs.svh"

package scc_pkg;

   // Host bus as driven by the CPU side
   typedef struct packed {
      logic       req;
      logic       wrt;
      logic [7:0] adr;
      logic [7:0] dbo;
   } scc_bus_t;

   // Wave memory view: wave number and sample index
   typedef struct packed {
      logic [2:0] num;
      logic [4:0] idx;
   } scc_wave_addr_t;

   // Register view: page, unused bit, register select
   typedef struct packed {
      logic [2:0] page;
      logic       spare;
      logic [3:0] sel;
   } scc_reg_addr_t;

   typedef union packed {
      scc_wave_addr_t wave;
      scc_reg_addr_t  regs;
   } scc_addr_u;

   // Per channel tone setup
   typedef struct packed {
      logic [11:0] freq;
      logic        restart;
   } scc_tone_cfg_t;

   // Mixer setup for all channels
   typedef struct packed {
      logic [`SCC_NUM_CH-1:0][3:0] vol;
      logic [`SCC_NUM_CH-1:0]      en;
      logic                        plus_active;
   } scc_mix_cfg_t;

   // Host side port of the wave memory
   typedef struct packed {
      logic       we;
      logic [7:0] adr;
      logic [7:0] data;
   } scc_ram_port_t;

endpackage

`default_nettype wire

// File: scc_bus_regs.sv
// One write per req pulse; dbi is combinational and returns FF outside the wave range of the mode
`timescale 1ns/10ps
`default_nettype none

`include "scc_defs.svh"

module scc_bus_regs import scc_pkg::*; (
   input  logic                            clk,
   input  logic                            reset,
   input  scc_bus_t                        bus,
   input  logic                            scc_plus_chip,
   input  logic                            scc_plus_mode,
   input  logic                            clkena,
   input  logic          [7:0]             ram_q,
   output logic                            ack,
   output logic          [7:0]             dbi,
   output scc_ram_port_t                   ram_port,
   output scc_tone_cfg_t [`SCC_NUM_CH-1:0] tone_cfg,
   output scc_mix_cfg_t                    mix_cfg
);

   scc_addr_u                    addr;
   logic                         req_dl;
   logic                         plus_active;
   logic [2:0]                   reg_page;
   logic [2:0]                   mode_page;
   logic [2:0]                   vol_ch;
   logic                         reg_wr;
   logic                         mode_wr;
   logic [7:0]                   wave_end;
   logic [7:0]                   ram_adr;
   logic                         ram_ce;
   logic                         ram_we;

   logic [`SCC_NUM_CH-1:0][11:0] freq_q;
   logic [`SCC_NUM_CH-1:0][3:0]  vol_q;
   logic [`SCC_NUM_CH-1:0]       en_q;
   logic [`SCC_NUM_CH-1:0]       rst_q;
   // Only deformation bit 5 (pointer restart) is kept
   logic                         mode_restart;

   assign addr        = bus.adr;
   assign plus_active = scc_plus_chip & scc_plus_mode;
   assign reg_page    = plus_active ? `SCC_PAGE_REG_PLUS : `SCC_PAGE_REG_SCC;
   assign mode_page   = scc_plus_chip ? `SCC_PAGE_MODE_PLUS : `SCC_PAGE_MODE_SCC;
   assign vol_ch      = 3'(addr.regs.sel - 4'd10);

   // Register writes need a rising req, mode writes do not
   assign reg_wr  = bus.req & ~req_dl & bus.wrt & (addr.regs.page == reg_page);
   assign mode_wr = bus.req & bus.wrt & (addr.regs.page == mode_page);

   always_ff @(posedge clk) begin
      if (reset) begin
         freq_q       <= '0;
         vol_q        <= '0;
         en_q         <= '0;
         rst_q        <= '0;
         mode_restart <= 1'b0;
         req_dl       <= 1'b0;
      end else begin
         if (reg_wr) begin
            if (addr.regs.sel < 4'd10) begin
               if (addr.regs.sel[0]) begin
                  freq_q[addr.regs.sel[3:1]][11:8] <= bus.dbo[3:0];
               end else begin
                  freq_q[addr.regs.sel[3:1]][7:0] <= bus.dbo;
               end
               rst_q[addr.regs.sel[3:1]] <= mode_restart;
            end else if (addr.regs.sel == 4'hF) begin
               en_q <= bus.dbo[`SCC_NUM_CH-1:0];
            end else begin
               vol_q[vol_ch] <= bus.dbo[3:0];
            end
         end else if (clkena) begin
            // Restart is seen by the tone counters on this clkena
            rst_q <= '0;
         end
         if (mode_wr) begin
            mode_restart <= bus.dbo[5];
         end
         req_dl <= bus.req;
      end
   end

   always_comb begin
      for (int c = 0; c < `SCC_NUM_CH; c++) begin
         tone_cfg[c].freq    = freq_q[c];
         tone_cfg[c].restart = rst_q[c];
      end
   end

   assign mix_cfg = '{vol: vol_q, en: en_q, plus_active: plus_active};

   // SCC+ chip in SCC mode mirrors wave 3 onto page 101 for reads
   always_comb begin
      ram_adr = bus.adr;
      if (~bus.wrt & scc_plus_chip & ~scc_plus_mode &
          (addr.regs.page == `SCC_PAGE_REG_PLUS)) begin
         ram_adr = {3'd3, addr.wave.idx};
      end
   end

   assign wave_end = plus_active ? 8'(5 * `SCC_WAVE_LEN) : 8'(4 * `SCC_WAVE_LEN);
   assign ram_ce   = bus.req & (ram_adr < wave_end);
   assign ram_we   = ram_ce & ~req_dl & bus.wrt;
   assign ram_port = '{we: ram_we, adr: ram_adr, data: bus.dbo};

   assign dbi = ram_ce ? ram_q : 8'hFF;
   assign ack = req_dl;

   // Ack answers each req rise and no second write is taken while it is high
   a_ack_rise: assert property (@(posedge clk) disable iff (reset) $rose(bus.req) |=> ack);
   a_one_write: assert property (@(posedge clk) disable iff (reset)
      ack |-> !(reg_wr || ram_port.we));
   // Writes bypass the read mirror and stay inside the waves of the mode
   a_we_range: assert property (@(posedge clk) disable iff (reset)
      ram_port.we |-> (ram_port.adr == bus.adr) &&
                      (bus.adr[7:5] <= (plus_active ? 3'd4 : 3'd3)));

endmodule

`default_nettype wire

// File: scc_tone.sv
// Pointers only move on clkena; a freq below 8 or a pending restart parks the pointer at 0
`timescale 1ns/10ps
`default_nettype none

`include "scc_defs.svh"

module scc_tone import scc_pkg::*; (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 clkena,
   input  scc_tone_cfg_t [`SCC_NUM_CH-1:0]      tone_cfg,
   output logic          [`SCC_NUM_CH-1:0][4:0] ptr
);

   // Period down-counters, one per channel
   logic [`SCC_NUM_CH-1:0][11:0] cnt;
   logic [`SCC_NUM_CH-1:0]       hold;
   logic [`SCC_NUM_CH-1:0]       wrap;

   // Hold when freq[11:3] is zero, which covers the inaudible range
   always_comb begin
      for (int c = 0; c < `SCC_NUM_CH; c++) begin
         hold[c] = (tone_cfg[c].freq[11:3] == 9'd0) | tone_cfg[c].restart;
         wrap[c] = (cnt[c] == 12'd0);
      end
   end

   // A step takes freq+1 clkena cycles: count down to 0, then reload
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt <= '0;
         ptr <= '0;
      end else if (clkena) begin
         for (int c = 0; c < `SCC_NUM_CH; c++) begin
            if (hold[c]) begin
               ptr[c] <= 5'd0;
               cnt[c] <= tone_cfg[c].freq;
            end else if (wrap[c]) begin
               // Pointer wraps naturally at the wave length
               ptr[c] <= ptr[c] + 5'd1;
               cnt[c] <= tone_cfg[c].freq;
            end else begin
               cnt[c] <= cnt[c] - 12'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: scc_wave_ram.sv
// Contents are undefined until written; port B data appears one clock after its address
`timescale 1ns/10ps
`default_nettype none

module scc_wave_ram import scc_pkg::*; (
   input  logic          clk,
   input  scc_ram_port_t port_a,
   output logic [7:0]    q_a,
   input  logic [7:0]    play_adr,
   output logic [7:0]    q_b
);

   logic [7:0] mem [256];
   logic [7:0] play_adr_q;

   // Host writes and playback address capture
   always_ff @(posedge clk) begin
      if (port_a.we) begin
         mem[port_a.adr] <= port_a.data;
      end
      play_adr_q <= play_adr;
   end

   // Host side read is combinational so dbi is valid with req
   assign q_a = mem[port_a.adr];
   assign q_b = mem[play_adr_q];

endmodule

`default_nettype wire

// File: scc_mixer.sv
// Free running six-slot frame; wave is refreshed once per frame and clamps wave 4 to 3 in SCC mode
`timescale 1ns/10ps
`default_nettype none

`include "scc_defs.svh"

module scc_mixer import scc_pkg::*; (
   input  logic                               clk,
   input  logic                               reset,
   input  logic        [`SCC_NUM_CH-1:0][4:0] ptr,
   input  scc_mix_cfg_t                       mix_cfg,
   output logic        [7:0]                  play_adr,
   input  logic        [7:0]                  q_b,
   output logic signed [14:0]                 wave
);

   logic        [2:0]  slot;
   logic        [2:0]  slot_d1;
   logic        [2:0]  slot_d2;
   logic        [2:0]  fetch_ch;
   logic        [2:0]  wave_num;
   logic        [2:0]  mix_ch;
   logic        [7:0]  sample_q;
   logic        [7:0]  sample_m;
   logic signed [12:0] prod_full;
   logic signed [11:0] prod;
   logic signed [14:0] acc;

   // Slot 0 carries no channel, slots 1..5 map to channels 0..4
   function automatic logic [2:0] slot_to_ch(input logic [2:0] s);
      slot_to_ch = (s == 3'd0) ? 3'd0 : s - 3'd1;
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         slot    <= 3'd0;
         slot_d1 <= 3'd0;
         slot_d2 <= 3'd0;
      end else begin
         if (slot == 3'(`SCC_NUM_SLOTS - 1)) begin
            slot <= 3'd0;
         end else begin
            slot <= slot + 3'd1;
         end
         slot_d1 <= slot;
         slot_d2 <= slot_d1;
      end
   end

   // Fetch stage; channel 4 reads wave 3 unless SCC+ mode is active
   assign fetch_ch = slot_to_ch(slot);
   assign wave_num = (!mix_cfg.plus_active && fetch_ch > 3'd3) ? 3'd3 : fetch_ch;
   assign play_adr = {wave_num, ptr[fetch_ch]};

   // RAM data for slot_d1 is valid now, align it with slot_d2
   always_ff @(posedge clk) begin
      sample_q <= q_b;
   end

   assign mix_ch    = slot_to_ch(slot_d2);
   assign sample_m  = mix_cfg.en[mix_ch] ? sample_q : 8'd0;
   // Signed sample times unsigned volume, result fits 12 bits
   assign prod_full = $signed(sample_m) * $signed({1'b0, mix_cfg.vol[mix_ch]});
   assign prod      = prod_full[11:0];

   always_ff @(posedge clk) begin
      if (reset) begin
         acc  <= '0;
         wave <= '0;
      end else if (slot_d2 == 3'd0) begin
         // Frame done: publish the sum and start over
         wave <= acc;
         acc  <= '0;
      end else begin
         acc <= acc + {{3{prod[11]}}, prod};
      end
   end

   a_slot_range: assert property (@(posedge clk) disable iff (reset)
      slot < 3'(`SCC_NUM_SLOTS));

endmodule

`default_nettype wire

// File: scc_top.sv
// Bus must be driven with plain levels; wave output lags register and memory writes by up to 18 clocks
`timescale 1ns/10ps
`default_nettype none

`include "scc_defs.svh"

module scc_top import scc_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  logic               clkena,
   input  scc_bus_t           bus,
   input  logic               scc_plus_chip,
   input  logic               scc_plus_mode,
   output logic               ack,
   output logic        [7:0]  dbi,
   output logic signed [14:0] wave
);

   scc_ram_port_t                   ram_port;
   logic          [7:0]             q_a;
   logic          [7:0]             q_b;
   logic          [7:0]             play_adr;
   scc_tone_cfg_t [`SCC_NUM_CH-1:0] tone_cfg;
   scc_mix_cfg_t                    mix_cfg;
   logic [`SCC_NUM_CH-1:0][4:0]     ptr;

   // Host interface and register file
   scc_bus_regs regs_i (
      .clk           (clk),
      .reset         (reset),
      .bus           (bus),
      .scc_plus_chip (scc_plus_chip),
      .scc_plus_mode (scc_plus_mode),
      .clkena        (clkena),
      .ram_q         (q_a),
      .ack           (ack),
      .dbi           (dbi),
      .ram_port      (ram_port),
      .tone_cfg      (tone_cfg),
      .mix_cfg       (mix_cfg)
   );

   scc_tone tone_i (
      .clk      (clk),
      .reset    (reset),
      .clkena   (clkena),
      .tone_cfg (tone_cfg),
      .ptr      (ptr)
   );

   scc_wave_ram ram_i (
      .clk      (clk),
      .port_a   (ram_port),
      .q_a      (q_a),
      .play_adr (play_adr),
      .q_b      (q_b)
   );

   // Playback side runs without clkena
   scc_mixer mixer_i (
      .clk      (clk),
      .reset    (reset),
      .ptr      (ptr),
      .mix_cfg  (mix_cfg),
      .play_adr (play_adr),
      .q_b      (q_b),
      .wave     (wave)
   );

endmodule

`default_nettype wire

// File: scc_checker.sv
// Samples at the rising edge; expects the bus and the strobe to change only on the falling edge
`timescale 1ns/10ps
`default_nettype none

module scc_checker import scc_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  scc_bus_t           bus,
   input  logic               ack,
   input  logic [7:0]         dbi,
   input  logic signed [14:0] wave,
   input  logic               exp_strobe,
   input  logic [7:0]         exp_kind,
   input  int                 exp_value,
   output int                 tests,
   output int                 errors
);

   logic               req_q;
   logic               win_on;
   logic               win_ramp;
   int                 win_bad;
   int                 wraps;
   logic signed [14:0] last;

   initial begin
      tests  = 0;
      errors = 0;
      req_q  = 1'b0;
      win_on = 1'b0;
   end

   always @(posedge clk) begin
      if (!reset && ack !== req_q) begin
         $display("mismatch at %0t: ack is %b one clock after req %b", $time, ack, req_q);
         errors++;
      end
      req_q = bus.req;
      // Window tracking, every change of wave is inspected
      if (win_on && wave !== last) begin
         if (win_ramp && wave == ((last + 15'sd1) & 15'sd31)) begin
            if (wave == 15'sd0) begin
               wraps++;
            end
         end else begin
            $display("mismatch at %0t: wave moved from %0d to %0d", $time, last, wave);
            win_bad++;
            errors++;
         end
         last = wave;
      end
      if (!reset && exp_strobe) begin
         case (exp_kind)
            "R": begin
               tests++;
               if (dbi !== exp_value[7:0]) begin
                  $display("mismatch at %0t: read at %h gave %h, expected %h",
                           $time, bus.adr, dbi, exp_value[7:0]);
                  errors++;
               end else begin
                  $display("test %0d: read at %h gave %h", tests, bus.adr, dbi);
               end
            end
            "S": begin
               tests++;
               if (wave !== 15'(exp_value)) begin
                  $display("mismatch at %0t: wave is %0d, expected %0d", $time, wave, exp_value);
                  errors++;
               end else begin
                  $display("test %0d: settled wave %0d", tests, wave);
               end
            end
            "P", "H": begin
               win_on   = 1'b1;
               win_ramp = (exp_kind == "P");
               win_bad  = 0;
               wraps    = 0;
               last     = wave;
            end
            default: begin
               tests++;
               win_on = 1'b0;
               if (win_ramp && win_bad == 0 && wraps == 0) begin
                  $display("test %0d: the ramp never wrapped inside its window", tests);
                  errors++;
               end else if (win_bad == 0) begin
                  $display("test %0d: %s window clean, %0d wraps", tests,
                           win_ramp ? "ramp" : "hold", wraps);
               end else begin
                  $display("test %0d: window saw %0d bad steps", tests, win_bad);
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: tb_scc.sv
// Run from the project root so that scc_golden.txt is found; inputs change on the falling edge
`timescale 1ns/10ps
`default_nettype none

`include "scc_defs.svh"

module tb_scc import scc_pkg::*; ();

   // One line of the golden file
   typedef struct packed {
      logic [7:0] kind;
      logic [7:0] adr;
      logic [7:0] data;
      logic       chip;
      logic       mode;
      logic       ena;
      int         count;
      int         wait_cyc;
      int         check;
      int         value;
   } rec_t;

   logic               clk = 1'b0;
   logic               reset;
   logic               clkena;
   logic               scc_plus_chip;
   logic               scc_plus_mode;
   scc_bus_t           bus;
   logic               ack;
   logic [7:0]         dbi;
   logic signed [14:0] wave;
   logic               exp_strobe;
   logic [7:0]         exp_kind;
   int                 exp_value;
   int                 tests;
   int                 errors;
   int                 cycles = 0;
   int                 limit = 0;
   rec_t               recs[$];

   always #5 clk = ~clk;

   scc_top dut_i (
      .clk           (clk),
      .reset         (reset),
      .clkena        (clkena),
      .bus           (bus),
      .scc_plus_chip (scc_plus_chip),
      .scc_plus_mode (scc_plus_mode),
      .ack           (ack),
      .dbi           (dbi),
      .wave          (wave)
   );

   scc_checker check_i (
      .clk        (clk),
      .reset      (reset),
      .bus        (bus),
      .ack        (ack),
      .dbi        (dbi),
      .wave       (wave),
      .exp_strobe (exp_strobe),
      .exp_kind   (exp_kind),
      .exp_value  (exp_value),
      .tests      (tests),
      .errors     (errors)
   );

   // Register page of the current mode, where adr[4] is free
   function automatic logic [2:0] reg_page();
      return (scc_plus_chip && scc_plus_mode) ? `SCC_PAGE_REG_PLUS : `SCC_PAGE_REG_SCC;
   endfunction

   task automatic load_golden();
      int               fd;
      int               n;
      int               f0;
      int               f1;
      int               f2;
      int               f3;
      int               f4;
      int               f5;
      logic [7:0]       ch;
      string            line;
      rec_t             r;
      fd = $fopen("scc_golden.txt", "r");
      if (fd == 0) begin
         $display("cannot open scc_golden.txt, nothing to run");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         ch   = 8'h00;
         f2   = 1;
         n    = $fgets(line, fd);
         n    = $sscanf(line, "%c", ch);
         r    = '0;
         r.kind = ch;
         if (ch == "W" || ch == "R") begin
            n = $sscanf(line, "%c %h %h %d", ch, f0, f1, f2);
            r.adr   = 8'(f0);
            r.data  = 8'(f1);
            r.count = f2;
         end else if (ch == "S") begin
            n = $sscanf(line, "%c %d %d %d %d %d %d", ch, f0, f1, f2, f3, f4, f5);
            r.chip     = f0[0];
            r.mode     = f1[0];
            r.ena      = f2[0];
            r.wait_cyc = f3;
            r.check    = f4;
            r.value    = f5;
         end
         if (ch == "W" || ch == "R" || ch == "S") begin
            recs.push_back(r);
            limit += 40;
         end
      end
      $fclose(fd);
      limit += 200;
   endtask

   // One req pulse, then a low clock so the next req is a new rise
   task automatic bus_cycle(input logic wrt, input logic [7:0] adr, input logic [7:0] data,
                            input logic [7:0] kind, input int value);
      bus        = '{req: 1'b1, wrt: wrt, adr: adr, dbo: data};
      exp_kind   = kind;
      exp_value  = value;
      exp_strobe = (kind != 8'h00);
      @(negedge clk);
      bus        = '{req: 1'b0, wrt: 1'b0, adr: adr, dbo: data};
      exp_strobe = 1'b0;
      @(negedge clk);
   endtask

   task automatic pulse_expect(input logic [7:0] kind, input int value);
      exp_kind   = kind;
      exp_value  = value;
      exp_strobe = 1'b1;
      @(negedge clk);
      exp_strobe = 1'b0;
   endtask

   task automatic run_record(input rec_t r);
      logic [7:0] a;
      case (r.kind)
         "W": begin
            for (int i = 0; i < r.count; i++) begin
               a = r.adr + 8'(i);
               if (a[7:5] == reg_page()) begin
                  a[4] = 1'($urandom % 2);
               end
               bus_cycle(1'b1, a, r.data + 8'(i), 8'h00, 0);
            end
         end
         "R": bus_cycle(1'b0, r.adr, 8'h00, "R", int'(r.data));
         default: begin
            scc_plus_chip = r.chip;
            scc_plus_mode = r.mode;
            clkena        = r.ena;
            if (r.check == 1) begin
               pulse_expect("P", 0);
            end else if (r.check == 2) begin
               pulse_expect("H", 0);
            end
            repeat (r.wait_cyc) @(negedge clk);
            if (r.check == 0) begin
               pulse_expect("S", r.value);
            end else if (r.check != 3) begin
               pulse_expect("E", 0);
            end
         end
      endcase
   endtask

   initial begin
      reset         = 1'b1;
      clkena        = 1'b0;
      scc_plus_chip = 1'b0;
      scc_plus_mode = 1'b0;
      bus           = '0;
      exp_strobe    = 1'b0;
      exp_kind      = 8'h00;
      exp_value     = 0;
      void'($urandom(32314));
      load_golden();
      repeat (5) @(negedge clk);
      reset = 1'b0;
      foreach (recs[i]) begin
         run_record(recs[i]);
         repeat ($urandom % 4) @(negedge clk);
      end
      repeat (2) @(negedge clk);
      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0 && tests > 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Run limit grows with the number of records
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("timeout: the run passed its limit of %0d cycles", limit);
         $display("ERRORS FOUND");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: scc_golden.txt
# W adr data count: write count bytes from adr, data rising by one per byte; R adr dbi: read check
# S chip mode clkena wait check wave: check 0 exact wave, 1 ramp window, 2 hold window, 3 wait only
W 00 10 1
W 20 F0 1
W 40 20 1
W 60 05 1
R 00 10
R 60 05
R 85 FF
W 8A 03 1
W 8B 02 1
W 8C 01 1
W 8D 04 1
W 8E 05 1
W 8F 0F 1
S 0 0 0 18 0 68
W 8F 1F 1
S 0 0 0 18 0 93
W 8F 10 1
S 0 0 0 18 0 25
W 8F 00 1
S 1 1 0 18 0 0
W 80 7F 1
W AE 02 1
W AF 10 1
S 1 1 0 18 0 254
R 80 7F
W 65 3C 1
S 1 0 0 18 0 10
R A5 3C
W 00 00 32
W 8A 01 1
W 8F 01 1
S 0 0 0 18 0 0
W 80 08 1
S 0 0 1 330 1 0
S 0 0 0 20 3 0
S 0 0 0 40 2 0
W E0 20 1
W 80 08 1
S 0 0 1 4 3 0
S 0 0 0 18 0 0

// File: build.f
+incdir+.
scc_pkg.sv
scc_bus_regs.sv
scc_tone.sv
scc_wave_ram.sv
scc_mixer.sv
scc_top.sv
scc_checker.sv
tb_scc.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_scc
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)
